// ==== logic/acq_params.svh ====
// acquisition card constants
// channel count, data and count widths, FIFO depth and the host register map
`ifndef ACQ_PARAMS_SVH
`define ACQ_PARAMS_SVH

// channels and data
`define ACQ_ADC_NUM     4
`define ACQ_DATA_W      16
`define ACQ_FIFO_DEPTH  16
// holds 0 to ACQ_FIFO_DEPTH
`define ACQ_CNT_W       5
`define ACQ_DO_NUM      8

// host register port
`define ACQ_REG_AW      4
`define ACQ_REG_W       32

// register map, writable registers first
`define ACQ_ADDR_CTRL   0
`define ACQ_ADDR_THRESH 1
`define ACQ_ADDR_IRQ_EN 2
`define ACQ_ADDR_INZ    3
`define ACQ_ADDR_OUTFIL 4
`define ACQ_ADDR_DO     5
`define ACQ_ADDR_STATUS 8
`define ACQ_ADDR_COUNT0 9

`endif

// ==== logic/acq_pkg.sv ====
// acquisition card types
// host register requests, decoded configuration, status flags and counts
`default_nettype none

`include "acq_params.svh"

package acq_pkg;

    // host write, one-cycle strobe
    typedef struct packed {
        logic                   strb;
        logic [`ACQ_REG_AW-1:0] addr;
        logic [`ACQ_REG_W-1:0]  data;
    } reg_wr_t;

    // host read request, data returns one cycle later
    typedef struct packed {
        logic                   strb;
        logic [`ACQ_REG_AW-1:0] addr;
    } reg_rd_t;

    typedef struct packed {
        logic                    fifo_rst;
        logic [`ACQ_CNT_W-1:0]   in_thresh;
        logic [1:0]              irq_en;
        logic [`ACQ_ADC_NUM-1:0] inz_switch;
        // one filter switch per DAC, same count as the ADCs
        logic [`ACQ_ADC_NUM-1:0] outfil_switch;
        logic [`ACQ_DO_NUM-1:0]  do_word;
    } acq_cfg_t;

    // spread over bits 4, 2 and 0 of the status word
    typedef struct packed {
        logic almost_full;
        logic any_full;
        logic ch0_ready;
    } acq_status_t;

    typedef logic [`ACQ_ADC_NUM-1:0][`ACQ_CNT_W-1:0] cnt_vec_t;

endpackage

`default_nettype wire

// ==== logic/acq_ctrl_regs.sv ====
// host control register file
// six writable registers decoded into the card configuration, plus a
// registered read-back mux over the control registers, status and counts
`timescale 1ns/1ps
`default_nettype none

`include "acq_params.svh"

module acq_ctrl_regs
    import acq_pkg::*;
(
    input  wire                    core_clk,
    input  wire                    rst_n,
    input  reg_wr_t                wr,
    input  reg_rd_t                rd,
    input  acq_status_t            status,
    input  cnt_vec_t               counts,
    output acq_cfg_t               cfg,
    output logic [`ACQ_REG_W-1:0]  rd_data,
    output logic                   rd_valid
);

    logic [`ACQ_ADDR_DO:0][`ACQ_REG_W-1:0] ctrl_q;
    logic [`ACQ_REG_W-1:0]                 rd_mux;

    // writes above the last control register fall through
    always_ff @(posedge core_clk) begin
        if (!rst_n) begin
            ctrl_q <= '0;
        end else if (wr.strb) begin
            for (int i = 0; i <= `ACQ_ADDR_DO; i++) begin
                if (wr.addr == `ACQ_REG_AW'(i)) begin
                    ctrl_q[i] <= wr.data;
                end
            end
        end
    end

    // field decode
    always_comb begin
        cfg.fifo_rst      = ctrl_q[`ACQ_ADDR_CTRL][0];
        cfg.in_thresh     = ctrl_q[`ACQ_ADDR_THRESH][`ACQ_CNT_W-1:0];
        cfg.irq_en        = ctrl_q[`ACQ_ADDR_IRQ_EN][1:0];
        cfg.inz_switch    = ctrl_q[`ACQ_ADDR_INZ][`ACQ_ADC_NUM-1:0];
        cfg.outfil_switch = ctrl_q[`ACQ_ADDR_OUTFIL][`ACQ_ADC_NUM-1:0];
        cfg.do_word       = ctrl_q[`ACQ_ADDR_DO][`ACQ_DO_NUM-1:0];
    end

    // unmapped addresses read zero
    always_comb begin
        rd_mux = '0;
        for (int i = 0; i <= `ACQ_ADDR_DO; i++) begin
            if (rd.addr == `ACQ_REG_AW'(i)) begin
                rd_mux = ctrl_q[i];
            end
        end
        if (rd.addr == `ACQ_REG_AW'(`ACQ_ADDR_STATUS)) begin
            rd_mux[0] = status.ch0_ready;
            rd_mux[2] = status.any_full;
            rd_mux[4] = status.almost_full;
        end
        for (int i = 0; i < `ACQ_ADC_NUM; i++) begin
            if (rd.addr == `ACQ_REG_AW'(`ACQ_ADDR_COUNT0 + i)) begin
                rd_mux = `ACQ_REG_W'(counts[i]);
            end
        end
    end

    always_ff @(posedge core_clk) begin
        if (!rst_n) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd.strb;
        end
    end

    always_ff @(posedge core_clk) begin
        if (rd.strb) begin
            rd_data <= rd_mux;
        end
    end

    // every read strobe answers on the very next cycle, and nothing else does
    a_rd_latency: assert property (@(posedge core_clk) disable iff (!rst_n)
        1'b1 |=> (rd_valid == $past(rd.strb)));

endmodule

`default_nettype wire

// ==== logic/acq_sample_fifo.sv ====
// per-channel sample FIFO
// circular buffer with occupancy count, level flush and registered pop output
`timescale 1ns/1ps
`default_nettype none

`include "acq_params.svh"

module acq_sample_fifo (
    input  wire                     core_clk,
    input  wire                     rst_n,
    input  wire                     flush,
    input  wire                     push,
    input  wire  [`ACQ_DATA_W-1:0]  din,
    input  wire                     pop,
    output logic [`ACQ_DATA_W-1:0]  dout,
    output logic                    dout_valid,
    output logic                    full,
    output logic [`ACQ_CNT_W-1:0]   count
);

    localparam int PTR_W = $clog2(`ACQ_FIFO_DEPTH);

    logic [`ACQ_DATA_W-1:0] mem [`ACQ_FIFO_DEPTH];
    logic [PTR_W-1:0]       wr_ptr;
    logic [PTR_W-1:0]       rd_ptr;
    logic                   do_push;
    logic                   do_pop;

    assign full    = (count == `ACQ_CNT_W'(`ACQ_FIFO_DEPTH));
    assign do_push = push && !full;
    // pop on an empty FIFO is dropped
    assign do_pop  = pop && (count != '0);

    always_ff @(posedge core_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
        if (do_pop) begin
            dout <= mem[rd_ptr];
        end
    end

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge core_clk) begin
        if (!rst_n || flush) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            dout_valid <= 1'b0;
        end else begin
            dout_valid <= do_pop;
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_count_range: assert property (@(posedge core_clk) disable iff (!rst_n)
        count <= `ACQ_CNT_W'(`ACQ_FIFO_DEPTH));
    // the source side must stall on full
    a_no_push_full: assert property (@(posedge core_clk) disable iff (!rst_n)
        !(push && full));

endmodule

`default_nettype wire

// ==== logic/acq_status_irq.sv ====
// status flags and interrupt
// almost-full of channel 0 against the threshold, any-channel full, and an
// interrupt registered from the enabled flags
`timescale 1ns/1ps
`default_nettype none

`include "acq_params.svh"

module acq_status_irq
    import acq_pkg::*;
(
    input  wire                     core_clk,
    input  wire                     rst_n,
    input  acq_cfg_t                cfg,
    input  cnt_vec_t                counts,
    input  wire  [`ACQ_ADC_NUM-1:0] full,
    output acq_status_t             status,
    output logic                    interrupt
);

    logic irq_next;

    always_comb begin
        status.ch0_ready   = !full[0];
        status.any_full    = |full;
        // only channel 0 is compared with the threshold
        status.almost_full = counts[0] > cfg.in_thresh;
    end

    assign irq_next = (cfg.irq_en[0] && status.almost_full)
                   || (cfg.irq_en[1] && status.any_full);

    always_ff @(posedge core_clk) begin
        if (!rst_n) begin
            interrupt <= 1'b0;
        end else begin
            interrupt <= irq_next;
        end
    end

    // masked flags never reach the pin
    a_irq_masked: assert property (@(posedge core_clk) disable iff (!rst_n)
        (cfg.irq_en == 2'b00) |=> !interrupt);

endmodule

`default_nettype wire

// ==== logic/acq_card.sv ====
// acquisition card top
// host registers, one sample FIFO per ADC channel, pop steering back to the
// host, digital output register and interrupt
`timescale 1ns/1ps
`default_nettype none

`include "acq_params.svh"

module acq_card
    import acq_pkg::*;
#(
    localparam int CH_W = $clog2(`ACQ_ADC_NUM)
) (
    input  wire                                        core_clk,
    input  wire                                        rst_n,
    input  wire                                        sys_en,
    input  reg_wr_t                                    wr,
    input  reg_rd_t                                    rd,
    input  wire  [`ACQ_ADC_NUM-1:0][`ACQ_DATA_W-1:0]   ad_din,
    input  wire  [`ACQ_ADC_NUM-1:0]                    ad_valid,
    output logic [`ACQ_ADC_NUM-1:0]                    ad_ready,
    input  wire                                        pop,
    input  wire  [CH_W-1:0]                            pop_ch,
    output logic [`ACQ_REG_W-1:0]                      rd_data,
    output logic                                       rd_valid,
    output logic [`ACQ_DATA_W-1:0]                     pop_data,
    output logic                                       pop_valid,
    output logic [`ACQ_DO_NUM-1:0]                     acq_do,
    output logic [`ACQ_ADC_NUM-1:0]                    adc_inz_switch,
    output logic [`ACQ_ADC_NUM-1:0]                    dac_outfil_switch,
    output logic                                       interrupt
);

    acq_cfg_t                                  cfg;
    acq_status_t                               status;
    cnt_vec_t                                  counts;
    logic [`ACQ_ADC_NUM-1:0]                   full;
    logic [`ACQ_ADC_NUM-1:0][`ACQ_DATA_W-1:0]  fifo_dout;
    logic [`ACQ_ADC_NUM-1:0]                   fifo_valid;

    acq_ctrl_regs ctrl_regs_i (
        .core_clk (core_clk),
        .rst_n    (rst_n),
        .wr       (wr),
        .rd       (rd),
        .status   (status),
        .counts   (counts),
        .cfg      (cfg),
        .rd_data  (rd_data),
        .rd_valid (rd_valid)
    );

    acq_status_irq status_irq_i (
        .core_clk  (core_clk),
        .rst_n     (rst_n),
        .cfg       (cfg),
        .counts    (counts),
        .full      (full),
        .status    (status),
        .interrupt (interrupt)
    );

    // ready drops on full, while disabled and while the FIFOs are held in reset
    for (genvar i = 0; i < `ACQ_ADC_NUM; i++) begin : g_ch
        assign ad_ready[i] = sys_en && !cfg.fifo_rst && !full[i];

        acq_sample_fifo fifo_i (
            .core_clk   (core_clk),
            .rst_n      (rst_n),
            .flush      (cfg.fifo_rst),
            .push       (ad_valid[i] && ad_ready[i]),
            .din        (ad_din[i]),
            .pop        (pop && (pop_ch == CH_W'(i))),
            .dout       (fifo_dout[i]),
            .dout_valid (fifo_valid[i]),
            .full       (full[i]),
            .count      (counts[i])
        );
    end

    // at most one channel answers per cycle
    always_comb begin
        pop_data = '0;
        for (int i = 0; i < `ACQ_ADC_NUM; i++) begin
            if (fifo_valid[i]) begin
                pop_data = pop_data | fifo_dout[i];
            end
        end
    end

    assign pop_valid         = |fifo_valid;
    assign adc_inz_switch    = cfg.inz_switch;
    assign dac_outfil_switch = cfg.outfil_switch;

    // digital outputs follow the register only while enabled
    always_ff @(posedge core_clk) begin
        if (!rst_n) begin
            acq_do <= '0;
        end else if (sys_en) begin
            acq_do <= cfg.do_word;
        end
    end

endmodule

`default_nettype wire

// ==== verif/acq_clk_gen.sv ====
// testbench clock and reset
// 20 ns core clock, reset held low for the first 5 cycles
`timescale 1ns/1ps
`default_nettype none

module acq_clk_gen (
    output logic core_clk,
    output logic rst_n
);

    initial begin
        core_clk = 1'b0;
        forever #10 core_clk = ~core_clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (5) @(posedge core_clk);
        #2 rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== verif/acq_card_checker.sv ====
// response checker for the acquisition card
// takes one expectation per table row, waits for the matching DUT answer
// and reports each check as it completes
`timescale 1ns/1ps
`default_nettype none

`include "acq_params.svh"

module acq_card_checker (
    input  wire                     core_clk,
    input  wire  [1:0]              req_kind,
    input  wire  [2:0]              req_pin,
    input  wire                     req_valid,
    input  wire  [`ACQ_REG_W-1:0]   req_exp,
    input  wire  [7:0]              req_test,
    input  wire  [`ACQ_REG_W-1:0]   rd_data,
    input  wire                     rd_valid,
    input  wire  [`ACQ_DATA_W-1:0]  pop_data,
    input  wire                     pop_valid,
    input  wire  [`ACQ_DO_NUM-1:0]  acq_do,
    input  wire  [`ACQ_ADC_NUM-1:0] adc_inz_switch,
    input  wire  [`ACQ_ADC_NUM-1:0] dac_outfil_switch,
    input  wire                     interrupt,
    input  wire  [`ACQ_ADC_NUM-1:0] ad_ready,
    output logic                    busy,
    output int                      err_cnt,
    output int                      chk_cnt
);

    function automatic logic [`ACQ_REG_W-1:0] pin_value(input logic [2:0] sel);
        case (sel)
            3'd0:    return `ACQ_REG_W'(acq_do);
            3'd1:    return `ACQ_REG_W'(adc_inz_switch);
            3'd2:    return `ACQ_REG_W'(dac_outfil_switch);
            3'd3:    return `ACQ_REG_W'(interrupt);
            default: return `ACQ_REG_W'(ad_ready);
        endcase
    endfunction

    function automatic string pin_name(input logic [2:0] sel);
        case (sel)
            3'd0:    return "acq_do";
            3'd1:    return "adc_inz_switch";
            3'd2:    return "dac_outfil_switch";
            3'd3:    return "interrupt";
            default: return "ad_ready";
        endcase
    endfunction

    // bad value or timeout
    task automatic note(input bit ok, input string sig, input logic [31:0] exp,
                        input logic [31:0] got);
        chk_cnt++;
        if (ok) begin
            $display("test %0d check %0d: ok", req_test, chk_cnt);
        end else begin
            err_cnt++;
            $display("[FAIL] t=%0t test %0d %s exp %h got %h", $time, req_test, sig, exp, got);
        end
    endtask

    task automatic wait_strobe(input bit is_pop, output bit seen);
        int n;
        seen = 1'b0;
        n = 0;
        while (!seen && n < 8) begin
            @(negedge core_clk);
            seen = is_pop ? pop_valid : rd_valid;
            n++;
        end
    endtask

    initial begin
        bit seen;
        busy    = 1'b0;
        err_cnt = 0;
        chk_cnt = 0;
        forever begin
            @(negedge core_clk);
            if (req_kind != 2'd0) begin
                busy = 1'b1;
                case (req_kind)
                    2'd1: begin
                        wait_strobe(1'b0, seen);
                        if (!seen) begin
                            chk_cnt++;
                            err_cnt++;
                            $display("test %0d: rd_valid never came after a read", req_test);
                        end else begin
                            note(rd_data == req_exp, "rd_data", req_exp, rd_data);
                        end
                    end
                    2'd2: begin
                        if (req_valid) begin
                            wait_strobe(1'b1, seen);
                            if (!seen) begin
                                chk_cnt++;
                                err_cnt++;
                                $display("test %0d: pop_valid never came after a pop", req_test);
                            end else begin
                                note(pop_data == req_exp[`ACQ_DATA_W-1:0], "pop_data",
                                     req_exp, `ACQ_REG_W'(pop_data));
                            end
                        end else begin
                            // empty channel answers nothing on the next cycle
                            @(negedge core_clk);
                            note(!pop_valid, "pop_valid", 32'h0, `ACQ_REG_W'(pop_valid));
                        end
                    end
                    default: begin
                        note(pin_value(req_pin) == req_exp, pin_name(req_pin), req_exp,
                             pin_value(req_pin));
                    end
                endcase
                busy = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verif/acq_card_tb.sv ====
// acquisition card testbench
// builds a table of host operations with expected answers and applies it
// row by row, one operation per cycle followed by one idle cycle
`timescale 1ns/1ps
`default_nettype none

`include "acq_params.svh"

module acq_card_tb
    import acq_pkg::*;
;

    localparam int OP_WR = 0, OP_RD = 1, OP_PUSH = 2, OP_POP = 3, OP_PIN = 4, OP_SYSEN = 5;
    // pin selectors for OP_PIN rows
    localparam int PIN_DO = 0, PIN_INZ = 1, PIN_FIL = 2, PIN_IRQ = 3, PIN_RDY = 4;

    typedef struct packed {
        logic [2:0]  op;
        logic [1:0]  ch;
        logic [3:0]  addr;
        logic [31:0] data;
        logic [31:0] exp;
        logic [7:0]  test;
    } row_t;

    logic core_clk, rst_n, sys_en, pop, interrupt, rd_valid, pop_valid;
    reg_wr_t wr;
    reg_rd_t rd;
    logic [`ACQ_ADC_NUM-1:0][`ACQ_DATA_W-1:0] ad_din;
    logic [`ACQ_ADC_NUM-1:0] ad_valid, ad_ready, adc_inz_switch, dac_outfil_switch;
    logic [1:0] pop_ch, req_kind;
    logic [2:0] req_pin;
    logic req_valid, busy;
    logic [`ACQ_REG_W-1:0] rd_data, req_exp;
    logic [`ACQ_DATA_W-1:0] pop_data;
    logic [`ACQ_DO_NUM-1:0] acq_do;
    logic [7:0] req_test;
    int err_cnt, chk_cnt, n_rows;
    integer seed;
    row_t rows [256];
    logic [15:0] smp [32];

    acq_clk_gen clk_gen_i (.core_clk(core_clk), .rst_n(rst_n));

    acq_card acq_card_i (
        .core_clk(core_clk), .rst_n(rst_n), .sys_en(sys_en), .wr(wr), .rd(rd),
        .ad_din(ad_din), .ad_valid(ad_valid), .ad_ready(ad_ready), .pop(pop),
        .pop_ch(pop_ch), .rd_data(rd_data), .rd_valid(rd_valid), .pop_data(pop_data),
        .pop_valid(pop_valid), .acq_do(acq_do), .adc_inz_switch(adc_inz_switch),
        .dac_outfil_switch(dac_outfil_switch), .interrupt(interrupt)
    );

    acq_card_checker checker_i (
        .core_clk(core_clk), .req_kind(req_kind), .req_pin(req_pin), .req_valid(req_valid),
        .req_exp(req_exp), .req_test(req_test), .rd_data(rd_data), .rd_valid(rd_valid),
        .pop_data(pop_data), .pop_valid(pop_valid), .acq_do(acq_do),
        .adc_inz_switch(adc_inz_switch), .dac_outfil_switch(dac_outfil_switch),
        .interrupt(interrupt), .ad_ready(ad_ready), .busy(busy), .err_cnt(err_cnt),
        .chk_cnt(chk_cnt)
    );

    task automatic add_row(input int op, input int ch, input int addr,
                           input logic [31:0] data, input logic [31:0] exp, input int test);
        rows[n_rows] = '{3'(op), 2'(ch), 4'(addr), data, exp, 8'(test)};
        n_rows++;
    endtask

    task automatic new_sample(input int idx);
        integer rnd;
        rnd = $random(seed);
        smp[idx] = rnd[15:0];
    endtask

    task automatic build_table();
        n_rows = 0;
        // 1: register read-back and outputs
        add_row(OP_WR, 0, 0, 32'ha5a5_0000, 0, 1);
        add_row(OP_RD, 0, 0, 0, 32'ha5a5_0000, 1);
        add_row(OP_WR, 0, 1, 32'h1c, 0, 1);
        add_row(OP_RD, 0, 1, 0, 32'h1c, 1);
        add_row(OP_WR, 0, 2, 32'h2, 0, 1);
        add_row(OP_RD, 0, 2, 0, 32'h2, 1);
        add_row(OP_WR, 0, 2, 32'h0, 0, 1);
        add_row(OP_WR, 0, 3, 32'h9, 0, 1);
        add_row(OP_RD, 0, 3, 0, 32'h9, 1);
        add_row(OP_PIN, 0, PIN_INZ, 0, 32'h9, 1);
        add_row(OP_WR, 0, 4, 32'h6, 0, 1);
        add_row(OP_RD, 0, 4, 0, 32'h6, 1);
        add_row(OP_PIN, 0, PIN_FIL, 0, 32'h6, 1);
        add_row(OP_WR, 0, 5, 32'h3c, 0, 1);
        add_row(OP_RD, 0, 5, 0, 32'h3c, 1);
        add_row(OP_PIN, 0, PIN_DO, 0, 32'h3c, 1);
        add_row(OP_RD, 0, 6, 0, 32'h0, 1);
        add_row(OP_SYSEN, 0, 0, 32'h0, 0, 1);
        add_row(OP_WR, 0, 5, 32'hc3, 0, 1);
        add_row(OP_PIN, 0, PIN_DO, 0, 32'h3c, 1);
        add_row(OP_SYSEN, 0, 0, 32'h1, 0, 1);
        add_row(OP_PIN, 0, PIN_DO, 0, 32'hc3, 1);
        // 2: order and counts on channels 0 and 2
        for (int i = 0; i < 10; i++) begin
            new_sample(i);
            add_row(OP_PUSH, (i % 2) * 2, 0, 32'(smp[i]), 0, 2);
        end
        add_row(OP_RD, 0, 9, 0, 32'd5, 2);
        add_row(OP_RD, 0, 11, 0, 32'd5, 2);
        for (int i = 0; i < 10; i++) begin
            add_row(OP_POP, (i % 2) * 2, 0, 32'h1, 32'(smp[i]), 2);
        end
        add_row(OP_POP, 1, 0, 32'h0, 0, 2);
        // 3: channel 3 runs full, last two samples stall
        for (int i = 0; i < 18; i++) begin
            new_sample(i);
            add_row(OP_PUSH, 3, 0, 32'(smp[i]), 0, 3);
        end
        add_row(OP_PIN, 0, PIN_RDY, 0, 32'h7, 3);
        add_row(OP_RD, 0, 12, 0, 32'd16, 3);
        add_row(OP_RD, 0, 8, 0, 32'h5, 3);
        for (int i = 0; i < 16; i++) begin
            add_row(OP_POP, 3, 0, 32'h1, 32'(smp[i]), 3);
        end
        // 4: channel 0 above threshold 3
        add_row(OP_WR, 0, 1, 32'h3, 0, 4);
        add_row(OP_WR, 0, 2, 32'h1, 0, 4);
        for (int i = 0; i < 5; i++) begin
            new_sample(i);
        end
        for (int i = 0; i < 4; i++) begin
            add_row(OP_PUSH, 0, 0, 32'(smp[i]), 0, 4);
        end
        add_row(OP_RD, 0, 8, 0, 32'h11, 4);
        add_row(OP_PIN, 0, PIN_IRQ, 0, 32'h1, 4);
        add_row(OP_POP, 0, 0, 32'h1, 32'(smp[0]), 4);
        add_row(OP_RD, 0, 8, 0, 32'h1, 4);
        add_row(OP_PIN, 0, PIN_IRQ, 0, 32'h0, 4);
        add_row(OP_WR, 0, 2, 32'h0, 0, 4);
        add_row(OP_PUSH, 0, 0, 32'(smp[4]), 0, 4);
        add_row(OP_RD, 0, 8, 0, 32'h11, 4);
        add_row(OP_PIN, 0, PIN_IRQ, 0, 32'h0, 4);
        // 5: FIFO reset, then pushes while disabled
        add_row(OP_WR, 0, 0, 32'h1, 0, 5);
        for (int i = 0; i < 4; i++) begin
            add_row(OP_RD, 0, 9 + i, 0, 32'd0, 5);
        end
        add_row(OP_POP, 0, 0, 32'h0, 0, 5);
        add_row(OP_PIN, 0, PIN_RDY, 0, 32'h0, 5);
        add_row(OP_WR, 0, 0, 32'h0, 0, 5);
        add_row(OP_SYSEN, 0, 0, 32'h0, 0, 5);
        add_row(OP_PUSH, 1, 0, 32'h1234, 0, 5);
        add_row(OP_PUSH, 0, 0, 32'h5678, 0, 5);
        add_row(OP_RD, 0, 10, 0, 32'd0, 5);
        add_row(OP_RD, 0, 9, 0, 32'd0, 5);
        add_row(OP_SYSEN, 0, 0, 32'h1, 0, 5);
    endtask

    task automatic clear_inputs();
        wr        = '0;
        rd        = '0;
        ad_valid  = '0;
        pop       = 1'b0;
        req_kind  = 2'd0;
    endtask

    initial begin
        row_t r;
        int n;
        bit hung;
        seed = 32'hf968;
        sys_en = 1'b1;
        ad_din = '0;
        pop_ch = '0;
        req_pin = '0;
        req_valid = 1'b0;
        req_exp = '0;
        req_test = '0;
        clear_inputs();
        build_table();
        hung = 1'b0;
        n = 0;
        while (rst_n !== 1'b1 && n < 20) begin
            @(posedge core_clk);
            n++;
        end
        if (rst_n !== 1'b1) begin
            $display("reset never released");
            hung = 1'b1;
        end else begin
            @(posedge core_clk);
            #2;
        end
        for (int i = 0; i < n_rows && !hung; i++) begin
            r = rows[i];
            req_test = r.test;
            req_exp  = r.exp;
            case (int'(r.op))
                OP_WR: wr = '{1'b1, r.addr, r.data};
                OP_RD: begin
                    rd = '{1'b1, r.addr};
                    req_kind = 2'd1;
                end
                OP_PUSH: begin
                    ad_din[r.ch]   = r.data[15:0];
                    ad_valid[r.ch] = 1'b1;
                end
                OP_POP: begin
                    pop       = 1'b1;
                    pop_ch    = r.ch;
                    req_valid = r.data[0];
                    req_kind  = 2'd2;
                end
                OP_PIN: begin
                    req_pin  = r.addr[2:0];
                    req_kind = 2'd3;
                end
                default: sys_en = r.data[0];
            endcase
            @(posedge core_clk);
            #2;
            clear_inputs();
            @(posedge core_clk);
            #2;
            n = 0;
            while (busy && n < 10) begin
                @(posedge core_clk);
                #2;
                n++;
            end
            if (busy) begin
                $display("checker stayed busy, DUT did not answer");
                hung = 1'b1;
            end
        end
        $display("%0d checks run, %0d failed", chk_cnt, err_cnt);
        if (err_cnt == 0 && !hung) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+logic
logic/acq_pkg.sv
logic/acq_ctrl_regs.sv
logic/acq_sample_fifo.sv
logic/acq_status_irq.sv
logic/acq_card.sv
verif/acq_clk_gen.sv
verif/acq_card_checker.sv
verif/acq_card_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the acquisition card testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module acq_card_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/Vacq_card_tb > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "^PASS: all tests$" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
